/* Makefile */
# verilator run of the branch prediction testbench

TOP := tb_bp_top

.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --assert -j 0 --top-module $(TOP) -f files.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* bench/tb_checks.svh */
/* compare tasks, instruction encoders and the reference prediction rule
   included into the branch prediction testbench module */

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ---------------------------------------------------------------------------
// compare tasks
// ---------------------------------------------------------------------------
task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR time %0d ns %s: got %b expected %b",
                            $time, what, got, exp));
    end
endtask

task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
        abort_run($sformatf("ERR time %0d ns %s: got %0d expected %0d",
                            $time, what, got, exp));
    end
endtask

task automatic check_kind(input string what, input pred_kind_e got, input pred_kind_e exp);
    if (got !== exp) begin
        abort_run($sformatf("ERR time %0d ns %s: got %s expected %s",
                            $time, what, got.name(), exp.name()));
    end
endtask

// whole prediction, field by field
task automatic check_entry(input string what, input pred_entry_t got, input pred_entry_t exp);
    if (got.pc !== exp.pc) begin
        abort_run($sformatf("ERR time %0d ns %s: pc 0x%h expected 0x%h",
                            $time, what, got.pc, exp.pc));
    end
    check_kind({what, " kind"}, got.kind, exp.kind);
    check_bit({what, " taken"}, got.taken, exp.taken);
    if (got.target !== exp.target) begin
        abort_run($sformatf("ERR time %0d ns %s: target 0x%h expected 0x%h",
                            $time, what, got.target, exp.target));
    end
endtask

// ---------------------------------------------------------------------------
// reference rule: taken goes to dest, not taken falls through to pc+4
// ---------------------------------------------------------------------------
function automatic pred_entry_t expect_entry(input logic [XLEN-1:0] pc,
                                             input pred_kind_e      kind,
                                             input logic            taken,
                                             input logic [XLEN-1:0] dest);
    pred_entry_t e;
    e.pc     = pc;
    e.kind   = kind;
    e.taken  = taken;
    e.target = taken ? dest : pc + 64'd4;
    return e;
endfunction

// beq x0, x0 with a 13-bit offset
function automatic logic [ILEN-1:0] enc_branch(input logic [12:0] off);
    return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], OPCODE_BRANCH};
endfunction

// jal x1 with a 21-bit offset
function automatic logic [ILEN-1:0] enc_jal(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPCODE_JAL};
endfunction

// jalr x0, 0(x1)
function automatic logic [ILEN-1:0] enc_jalr();
    return {12'd0, 5'd1, 3'b000, 5'd0, OPCODE_JALR};
endfunction

`endif

/* bench/tb_bp_top.sv */
/* testbench for the branch prediction unit
   directed tests of static rules, bht, btb and the credit flow */

`timescale 1ns/10ps

module tb_bp_top;
    import bp_pkg::*;

    localparam int unsigned CLK_PERIOD = 40;
    localparam int unsigned DRV_DELAY  = 2;
    // cycles before any wait gives up
    localparam int unsigned TIMEOUT    = 50;
    localparam int unsigned SEED       = 82;
    // addi x1, x1, 1
    localparam logic [ILEN-1:0] ALU_INSTR = 32'h0010_8093;

    logic            clk_i;
    logic            rst_ni;
    logic            fetch_valid_i;
    logic [XLEN-1:0] fetch_pc_i;
    logic [ILEN-1:0] fetch_instr_i;
    logic            in_credit_o;
    logic            pred_valid_o;
    logic [XLEN-1:0] pred_pc_o;
    logic            pred_taken_o;
    logic [XLEN-1:0] pred_target_o;
    pred_kind_e      pred_kind_o;
    logic            out_credit_i;
    logic            upd_valid_i;
    upd_kind_e       upd_kind_i;
    logic [XLEN-1:0] upd_pc_i;
    logic            upd_taken_i;
    logic [XLEN-1:0] upd_target_i;
    logic            upd_clear_i;
    logic            flush_bp_i;

    // upstream credit model, spent by the driver and returned by the monitor
    int              credits_spent;
    int              credit_pulses;
    // received predictions and the read position of the tests
    pred_entry_t     got_mem [$];
    int unsigned     rd_idx;
    pred_entry_t     mon_entry;

    bp_top UUT (.*);

    `include "tb_checks.svh"

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk_i) begin
        if (in_credit_o) begin
            credit_pulses = credit_pulses + 1;
        end
        if (pred_valid_o) begin
            mon_entry.pc     = pred_pc_o;
            mon_entry.taken  = pred_taken_o;
            mon_entry.target = pred_target_o;
            mon_entry.kind   = pred_kind_o;
            got_mem.push_back(mon_entry);
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #DRV_DELAY;
    endtask

    function automatic logic [XLEN-1:0] rand_pc();
        return {32'h0000_0000, $urandom} & ~64'd3;
    endfunction

    // ---------------------------------------------------------------------------
    // drivers
    // ---------------------------------------------------------------------------
    task automatic send_fetch(input logic [XLEN-1:0] pc, input logic [ILEN-1:0] instr);
        int unsigned waited;
        waited = 0;
        // upstream sends only while it holds a credit
        while (int'(IN_CREDITS) - credits_spent + credit_pulses == 0) begin
            if (waited == TIMEOUT) begin
                abort_run("timeout: no input credit came back from the DUT");
            end
            next_cycle();
            waited++;
        end
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        fetch_instr_i = instr;
        credits_spent = credits_spent + 1;
        next_cycle();
        fetch_valid_i = 1'b0;
    endtask

    task automatic send_update(input upd_kind_e kind, input logic [XLEN-1:0] pc,
                               input logic taken, input logic [XLEN-1:0] dest,
                               input logic clear);
        upd_valid_i  = 1'b1;
        upd_kind_i   = kind;
        upd_pc_i     = pc;
        upd_taken_i  = taken;
        upd_target_i = dest;
        upd_clear_i  = clear;
        next_cycle();
        upd_valid_i  = 1'b0;
        upd_clear_i  = 1'b0;
    endtask

    task automatic flush_predictors();
        flush_bp_i = 1'b1;
        next_cycle();
        flush_bp_i = 1'b0;
    endtask

    task automatic return_credit();
        out_credit_i = 1'b1;
        next_cycle();
        out_credit_i = 1'b0;
    endtask

    task automatic wait_preds(input int unsigned n);
        int unsigned waited;
        waited = 0;
        while (got_mem.size() < rd_idx + n) begin
            if (waited == TIMEOUT) begin
                abort_run($sformatf("timeout: %0d predictions expected, %0d arrived",
                                    n, got_mem.size() - rd_idx));
            end
            next_cycle();
            waited++;
        end
    endtask

    task automatic take_pred(output pred_entry_t e);
        e = got_mem[rd_idx];
        rd_idx++;
    endtask

    // one fetch in, one prediction out, credit handed back
    task automatic predict_one(input string what, input logic [XLEN-1:0] pc,
                               input logic [ILEN-1:0] instr, input pred_entry_t exp);
        pred_entry_t got;
        send_fetch(pc, instr);
        wait_preds(1);
        take_pred(got);
        check_entry(what, got, exp);
        return_credit();
    endtask

    // ---------------------------------------------------------------------------
    // tests
    // ---------------------------------------------------------------------------
    task automatic test_after_reset();
        repeat (6) begin
            check_bit("pred_valid_o after reset", pred_valid_o, 1'b0);
            check_bit("in_credit_o after reset", in_credit_o, 1'b0);
            next_cycle();
        end
    endtask

    task automatic test_static_rules();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] off;
        pc  = rand_pc();
        off = -XLEN'(2 * (1 + ($urandom % 1000)));
        predict_one("backward branch", pc, enc_branch(off[12:0]),
                    expect_entry(pc, STATIC, 1'b1, pc + off));
        pc  = rand_pc();
        off = XLEN'(2 * (1 + ($urandom % 2000)));
        predict_one("forward branch", pc, enc_branch(off[12:0]),
                    expect_entry(pc, STATIC, 1'b0, pc + off));
        pc  = rand_pc();
        off = XLEN'(2 * (1 + ($urandom % 500000)));
        if ($urandom % 2 == 1) begin
            off = -off;
        end
        predict_one("jal", pc, enc_jal(off[20:0]), expect_entry(pc, JUMP, 1'b1, pc + off));
        pc = rand_pc();
        predict_one("alu", pc, ALU_INSTR, expect_entry(pc, NONE, 1'b0, '0));
    endtask

    task automatic test_bht_training();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] off;
        logic [ILEN-1:0] instr;
        pc    = rand_pc();
        off   = -XLEN'(2 * (1 + ($urandom % 1000)));
        instr = enc_branch(off[12:0]);
        // counter 0 to 1, still not taken although backward
        send_update(UPD_BHT, pc, 1'b1, '0, 1'b0);
        predict_one("bht one update", pc, instr, expect_entry(pc, DYNAMIC, 1'b0, pc + off));
        send_update(UPD_BHT, pc, 1'b1, '0, 1'b0);
        predict_one("bht two updates", pc, instr, expect_entry(pc, DYNAMIC, 1'b1, pc + off));
        flush_predictors();
        predict_one("bht after flush", pc, instr, expect_entry(pc, STATIC, 1'b1, pc + off));
    endtask

    task automatic test_btb();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] dest;
        pc   = rand_pc();
        dest = rand_pc();
        predict_one("jalr cold", pc, enc_jalr(), expect_entry(pc, INDIRECT_MISS, 1'b0, '0));
        send_update(UPD_BTB, pc, 1'b1, dest, 1'b0);
        predict_one("jalr after write", pc, enc_jalr(), expect_entry(pc, INDIRECT, 1'b1, dest));
        send_update(UPD_BTB, pc, 1'b1, dest, 1'b1);
        predict_one("jalr after clear", pc, enc_jalr(),
                    expect_entry(pc, INDIRECT_MISS, 1'b0, '0));
    endtask

    task automatic test_credits_and_order();
        pred_entry_t     exp_q [$];
        pred_entry_t     got;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] off;
        check_count("upstream credits before burst",
                    int'(IN_CREDITS) - credits_spent + credit_pulses, IN_CREDITS);
        // spend every upstream credit, jal and alu alternating
        for (int i = 0; i < int'(IN_CREDITS); i++) begin
            pc  = rand_pc();
            off = XLEN'(4 * (1 + ($urandom % 1000)));
            if (i % 2 == 0) begin
                exp_q.push_back(expect_entry(pc, JUMP, 1'b1, pc + off));
                send_fetch(pc, enc_jal(off[20:0]));
            end else begin
                exp_q.push_back(expect_entry(pc, NONE, 1'b0, '0));
                send_fetch(pc, ALU_INSTR);
            end
        end
        wait_preds(OUT_CREDITS);
        repeat (8) begin
            next_cycle();
        end
        check_count("predictions without returned credit",
                    got_mem.size() - rd_idx, OUT_CREDITS);
        repeat (IN_CREDITS) begin
            return_credit();
        end
        wait_preds(IN_CREDITS);
        foreach (exp_q[i]) begin
            take_pred(got);
            check_entry($sformatf("burst entry %0d", i), got, exp_q[i]);
        end
        check_count("credit pulses against predictions", credit_pulses, got_mem.size());
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni        = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        fetch_instr_i = '0;
        out_credit_i  = 1'b0;
        upd_valid_i   = 1'b0;
        upd_kind_i    = UPD_BHT;
        upd_pc_i      = '0;
        upd_taken_i   = 1'b0;
        upd_target_i  = '0;
        upd_clear_i   = 1'b0;
        flush_bp_i    = 1'b0;
        credits_spent = 0;
        credit_pulses = 0;
        rd_idx        = 0;
        repeat (2) begin
            @(posedge clk_i);
        end
        #DRV_DELAY;
        rst_ni = 1'b1;

        test_after_reset();
        test_static_rules();
        test_bht_training();
        test_btb();
        test_credits_and_order();

        if (got_mem.size() == rd_idx && credit_pulses == got_mem.size()) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("unexpected predictions or credits left at the end of the run");
        end
    end

endmodule

/* files.f */
+incdir+bench
verilog/bp_pkg.sv
verilog/instr_scan.sv
verilog/bht.sv
verilog/btb.sv
verilog/bp_select.sv
verilog/pred_queue.sv
verilog/bp_top.sv
bench/tb_bp_top.sv

/* verilog/bht.sv */
/* branch history table
   2-bit saturating counters with valid bits, one lookup and one update port */

`timescale 1ns/10ps

module bht (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic [bp_pkg::XLEN-1:0] lookup_pc_i,
    input  logic                    upd_en_i,
    input  logic [bp_pkg::XLEN-1:0] upd_pc_i,
    input  logic                    upd_taken_i,
    output logic                    valid_o,
    output logic                    taken_o
);
    import bp_pkg::*;

    // table state
    logic                 valid_q [BHT_ENTRIES];
    logic [1:0]           cnt_q   [BHT_ENTRIES];

    logic [BHT_IDX_W-1:0] lookup_idx;
    logic [BHT_IDX_W-1:0] upd_idx;
    logic [1:0]           upd_cnt;
    logic [1:0]           next_cnt;

    // index with the pc bits just above the word offset
    assign lookup_idx = lookup_pc_i[BHT_IDX_W+PC_OFFSET-1:PC_OFFSET];
    assign upd_idx    = upd_pc_i[BHT_IDX_W+PC_OFFSET-1:PC_OFFSET];

    // weakly and strongly taken both predict taken
    assign valid_o = valid_q[lookup_idx];
    assign taken_o = cnt_q[lookup_idx][1];

    // ---------------------------------------------------------------------------
    // counter step
    // ---------------------------------------------------------------------------
    always_comb begin
        upd_cnt  = cnt_q[upd_idx];
        next_cnt = upd_cnt;
        // saturate at both ends
        if (upd_taken_i && (upd_cnt != 2'b11)) begin
            next_cnt = upd_cnt + 2'd1;
        end else if (!upd_taken_i && (upd_cnt != 2'b00)) begin
            next_cnt = upd_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                cnt_q[i]   <= 2'b00;
            end
        end else if (flush_i) begin
            // flushed entries restart weakly taken
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                cnt_q[i]   <= 2'b10;
            end
        end else if (upd_en_i) begin
            valid_q[upd_idx] <= 1'b1;
            cnt_q[upd_idx]   <= next_cnt;
        end
    end

    // a resolved branch from the backend must carry a known pc
    a_upd_idx_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        upd_en_i |-> !$isunknown(upd_idx)
    );

endmodule

/* verilog/bp_pkg.sv */
/* branch prediction package
   widths, table sizes, credit counts, opcodes and the shared types */

package bp_pkg;

    // ---------------------------------------------------------------------------
    // datapath widths
    // ---------------------------------------------------------------------------
    // pc, target and immediate width
    localparam int unsigned XLEN = 64;
    // uncompressed instructions only
    localparam int unsigned ILEN = 32;

    // ---------------------------------------------------------------------------
    // predictor tables
    // ---------------------------------------------------------------------------
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = $clog2(BHT_ENTRIES);
    localparam int unsigned BTB_ENTRIES = 8;
    localparam int unsigned BTB_IDX_W   = $clog2(BTB_ENTRIES);
    // aligned 32-bit fetch, low pc bits carry no information
    localparam int unsigned PC_OFFSET   = 2;

    // ---------------------------------------------------------------------------
    // credit flow control
    // ---------------------------------------------------------------------------
    // upstream credits, also the queue depth
    localparam int unsigned IN_CREDITS  = 4;
    // credits toward the downstream after reset
    localparam int unsigned OUT_CREDITS = 2;
    localparam int unsigned Q_PTR_W     = $clog2(IN_CREDITS);
    localparam int unsigned Q_CNT_W     = $clog2(IN_CREDITS + 1);
    localparam int unsigned OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

    // rv32/64 base opcodes of interest
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR   = 7'b1100111;

    // source of a prediction
    typedef enum logic [2:0] {
        NONE          = 3'd0,
        STATIC        = 3'd1,
        DYNAMIC       = 3'd2,
        JUMP          = 3'd3,
        INDIRECT      = 3'd4,
        INDIRECT_MISS = 3'd5
    } pred_kind_e;

    // which predictor a resolved branch trains
    typedef enum logic {
        UPD_BHT = 1'b0,
        UPD_BTB = 1'b1
    } upd_kind_e;

    // one prediction as it sits in the queue
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic            taken;
        logic [XLEN-1:0] target;
        pred_kind_e      kind;
    } pred_entry_t;

endpackage

/* verilog/bp_select.sv */
/* prediction select
   merges scan flags, bht and btb lookups into taken, target and kind */

`timescale 1ns/10ps

module bp_select (
    input  logic                    [bp_pkg::XLEN-1:0] pc_i,
    input  logic                                       is_branch_i,
    input  logic                                       is_jal_i,
    input  logic                                       is_jalr_i,
    input  logic                    [bp_pkg::XLEN-1:0] imm_i,
    input  logic                                       bht_valid_i,
    input  logic                                       bht_taken_i,
    input  logic                                       btb_valid_i,
    input  logic                    [bp_pkg::XLEN-1:0] btb_target_i,
    output bp_pkg::pred_entry_t                        entry_o
);
    import bp_pkg::*;

    logic [XLEN-1:0] seq_pc;
    logic [XLEN-1:0] rel_target;

    // fall-through and pc-relative targets
    assign seq_pc     = pc_i + XLEN'(4);
    assign rel_target = pc_i + imm_i;

    always_comb begin
        entry_o.pc     = pc_i;
        entry_o.taken  = 1'b0;
        entry_o.target = seq_pc;
        entry_o.kind   = NONE;

        if (is_branch_i) begin
            if (bht_valid_i) begin
                entry_o.taken = bht_taken_i;
                entry_o.kind  = DYNAMIC;
            end else begin
                // backward taken, forward not taken
                entry_o.taken = imm_i[XLEN-1];
                entry_o.kind  = STATIC;
            end
            if (entry_o.taken) begin
                entry_o.target = rel_target;
            end
        end else if (is_jal_i) begin
            entry_o.taken  = 1'b1;
            entry_o.target = rel_target;
            entry_o.kind   = JUMP;
        end else if (is_jalr_i) begin
            // register target only known through the btb
            if (btb_valid_i) begin
                entry_o.taken  = 1'b1;
                entry_o.target = btb_target_i;
                entry_o.kind   = INDIRECT;
            end else begin
                entry_o.kind   = INDIRECT_MISS;
            end
        end
    end

    // the scanner decodes mutually exclusive opcodes
    always_comb begin
        a_flags_onehot: assert ($onehot0({is_branch_i, is_jal_i, is_jalr_i}));
    end

endmodule

/* verilog/bp_top.sv */
/* branch prediction unit top
   fetch capture stage, scanner, bht, btb, select and the prediction queue */

`timescale 1ns/10ps

module bp_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // fetch stream
    input  logic                     fetch_valid_i,
    input  logic [bp_pkg::XLEN-1:0]  fetch_pc_i,
    input  logic [bp_pkg::ILEN-1:0]  fetch_instr_i,
    output logic                     in_credit_o,
    // predictions
    output logic                     pred_valid_o,
    output logic [bp_pkg::XLEN-1:0]  pred_pc_o,
    output logic                     pred_taken_o,
    output logic [bp_pkg::XLEN-1:0]  pred_target_o,
    output bp_pkg::pred_kind_e       pred_kind_o,
    input  logic                     out_credit_i,
    // resolved branches
    input  logic                     upd_valid_i,
    input  bp_pkg::upd_kind_e        upd_kind_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_pc_i,
    input  logic                     upd_taken_i,
    input  logic [bp_pkg::XLEN-1:0]  upd_target_i,
    input  logic                     upd_clear_i,
    input  logic                     flush_bp_i
);
    import bp_pkg::*;

    // capture stage
    logic            cap_valid_q;
    logic [XLEN-1:0] cap_pc_q;
    logic [ILEN-1:0] cap_instr_q;

    logic            is_branch, is_jal, is_jalr;
    logic [XLEN-1:0] imm;
    logic            bht_valid, bht_taken;
    logic            btb_valid;
    logic [XLEN-1:0] btb_target;
    logic            bht_upd_en, btb_upd_en;
    pred_entry_t     sel_entry;
    pred_entry_t     q_entry;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cap_valid_q <= 1'b0;
            cap_pc_q    <= '0;
            cap_instr_q <= '0;
        end else begin
            cap_valid_q <= fetch_valid_i;
            if (fetch_valid_i) begin
                cap_pc_q    <= fetch_pc_i;
                cap_instr_q <= fetch_instr_i;
            end
        end
    end

    // update port split by kind
    assign bht_upd_en = upd_valid_i && (upd_kind_i == UPD_BHT);
    assign btb_upd_en = upd_valid_i && (upd_kind_i == UPD_BTB);

    instr_scan u_scan (
        .instr_i     (cap_instr_q),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .imm_o       (imm)
    );

    bht u_bht (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_bp_i),
        .lookup_pc_i (cap_pc_q),
        .upd_en_i    (bht_upd_en),
        .upd_pc_i    (upd_pc_i),
        .upd_taken_i (upd_taken_i),
        .valid_o     (bht_valid),
        .taken_o     (bht_taken)
    );

    btb u_btb (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_bp_i),
        .lookup_pc_i  (cap_pc_q),
        .upd_en_i     (btb_upd_en),
        .upd_pc_i     (upd_pc_i),
        .upd_target_i (upd_target_i),
        .upd_clear_i  (upd_clear_i),
        .valid_o      (btb_valid),
        .target_o     (btb_target)
    );

    bp_select u_select (
        .pc_i         (cap_pc_q),
        .is_branch_i  (is_branch),
        .is_jal_i     (is_jal),
        .is_jalr_i    (is_jalr),
        .imm_i        (imm),
        .bht_valid_i  (bht_valid),
        .bht_taken_i  (bht_taken),
        .btb_valid_i  (btb_valid),
        .btb_target_i (btb_target),
        .entry_o      (sel_entry)
    );

    // the capture valid qualifies the push, one cycle after fetch
    pred_queue u_queue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_i       (cap_valid_q),
        .entry_i      (sel_entry),
        .out_credit_i (out_credit_i),
        .in_credit_o  (in_credit_o),
        .valid_o      (pred_valid_o),
        .entry_o      (q_entry)
    );

    assign pred_pc_o     = q_entry.pc;
    assign pred_taken_o  = q_entry.taken;
    assign pred_target_o = q_entry.target;
    assign pred_kind_o   = q_entry.kind;

endmodule

/* verilog/btb.sv */
/* branch target buffer
   direct-mapped jalr targets with valid bits, write, clear and flush */

`timescale 1ns/10ps

module btb (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    flush_i,
    input  logic [bp_pkg::XLEN-1:0] lookup_pc_i,
    input  logic                    upd_en_i,
    input  logic [bp_pkg::XLEN-1:0] upd_pc_i,
    input  logic [bp_pkg::XLEN-1:0] upd_target_i,
    input  logic                    upd_clear_i,
    output logic                    valid_o,
    output logic [bp_pkg::XLEN-1:0] target_o
);
    import bp_pkg::*;

    logic                 valid_q  [BTB_ENTRIES];
    logic [XLEN-1:0]      target_q [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0] lookup_idx;
    logic [BTB_IDX_W-1:0] upd_idx;

    // no tag, aliasing pcs share an entry
    assign lookup_idx = lookup_pc_i[BTB_IDX_W+PC_OFFSET-1:PC_OFFSET];
    assign upd_idx    = upd_pc_i[BTB_IDX_W+PC_OFFSET-1:PC_OFFSET];

    assign valid_o  = valid_q[lookup_idx];
    assign target_o = target_q[lookup_idx];

    // ---------------------------------------------------------------------------
    // valid bits
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (flush_i) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en_i) begin
            // clear drops an entry that predicted a jump where none was
            valid_q[upd_idx] <= !upd_clear_i;
        end
    end

    // target storage, only meaningful under its valid bit
    always_ff @(posedge clk_i) begin
        if (upd_en_i && !upd_clear_i) begin
            target_q[upd_idx] <= upd_target_i;
        end
    end

endmodule

/* verilog/instr_scan.sv */
/* instruction scanner
   flags branch, jal and jalr and extracts the sign-extended immediate */

`timescale 1ns/10ps

module instr_scan (
    input  logic [bp_pkg::ILEN-1:0] instr_i,
    output logic                    is_branch_o,
    output logic                    is_jal_o,
    output logic                    is_jalr_o,
    output logic [bp_pkg::XLEN-1:0] imm_o
);
    import bp_pkg::*;

    logic [6:0]      opcode;
    logic [XLEN-1:0] sb_imm;
    logic [XLEN-1:0] uj_imm;

    assign opcode = instr_i[6:0];

    // plain opcode compare, funct3 is not checked
    assign is_branch_o = (opcode == OPCODE_BRANCH);
    assign is_jal_o    = (opcode == OPCODE_JAL);
    assign is_jalr_o   = (opcode == OPCODE_JALR);

    // conditional branch offset, bit 0 always zero
    assign sb_imm = {{(XLEN-12){instr_i[31]}},
                     instr_i[7],
                     instr_i[30:25],
                     instr_i[11:8],
                     1'b0};

    // jal offset, 21 bits incl. the implicit zero
    assign uj_imm = {{(XLEN-20){instr_i[31]}},
                     instr_i[19:12],
                     instr_i[20],
                     instr_i[30:21],
                     1'b0};

    // bit 3 is only set in the jal opcode among the three
    // jalr gets the sb pattern but its immediate is never used
    assign imm_o = instr_i[3] ? uj_imm : sb_imm;

endmodule

/* verilog/pred_queue.sv */
/* prediction queue
   circular buffer with upstream credit return and a downstream credit counter */

`timescale 1ns/10ps

module pred_queue (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                push_i,
    input  bp_pkg::pred_entry_t entry_i,
    input  logic                out_credit_i,
    output logic                in_credit_o,
    output logic                valid_o,
    output bp_pkg::pred_entry_t entry_o
);
    import bp_pkg::*;

    pred_entry_t          mem_q [IN_CREDITS];
    logic [Q_PTR_W-1:0]   wr_ptr_q;
    logic [Q_PTR_W-1:0]   rd_ptr_q;
    logic [Q_CNT_W-1:0]   count_q;
    logic [OUT_CNT_W-1:0] credit_q;
    logic                 pop;

    // drain one entry per cycle while the downstream has room
    assign pop = (count_q != '0) && (credit_q != '0);

    // ---------------------------------------------------------------------------
    // storage and output register
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
        if (pop) begin
            entry_o <= mem_q[rd_ptr_q];
        end
    end

    // ---------------------------------------------------------------------------
    // pointers, fill level and credits
    // ---------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            credit_q    <= OUT_CNT_W'(OUT_CREDITS);
            valid_o     <= 1'b0;
            in_credit_o <= 1'b0;
        end else begin
            // pointers wrap by themselves since the depth is a power of two
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + Q_PTR_W'(1);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + Q_PTR_W'(1);
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + Q_CNT_W'(1);
                2'b01:   count_q <= count_q - Q_CNT_W'(1);
                default: count_q <= count_q;
            endcase
            // returned credit and spent credit in one cycle cancel
            case ({out_credit_i, pop})
                2'b10:   credit_q <= credit_q + OUT_CNT_W'(1);
                2'b01:   credit_q <= credit_q - OUT_CNT_W'(1);
                default: credit_q <= credit_q;
            endcase
            // each pop frees a slot for the upstream
            valid_o     <= pop;
            in_credit_o <= pop;
        end
    end

    // the upstream honours its credits and never pushes into a full queue
    a_no_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        push_i |-> (count_q < Q_CNT_W'(IN_CREDITS))
    );

    // downstream never returns more credits than it was given
    a_credit_bound: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        credit_q <= OUT_CNT_W'(OUT_CREDITS)
    );

endmodule
